//--- logic/rv_isa_pkg.sv
/*
 * RV32 instruction-set definitions shared by the decoder and the ALU.
 * Other files refer to them by scoped name.
 */
package rv_isa_pkg;

    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;

    // Instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // Register-register ALU
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011   // Only WFI is accepted
    } opcode_e;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR} alu_op_e;

    localparam logic [31:0] NOP_INST = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] WFI_INST = 32'h1050_0073;

endpackage

//--- logic/rv_pipe_pkg.sv
/*
 * Pipeline widths, stage packets and the bus and status encodings.
 * Each stage register holds one of these packets.
 */
package rv_pipe_pkg;

    localparam int XLEN = 32;

    typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_cmd_e;
    typedef enum logic [1:0] {RUNNING, HALTED, ILLEGAL} status_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] npc;
        logic [31:0]     inst;
    } if_id_t;

    typedef struct packed {
        logic                             valid;
        logic [XLEN-1:0]                  pc;
        logic [XLEN-1:0]                  npc;
        logic [rv_isa_pkg::REG_IDX_W-1:0] rs1_idx;  // Zero when the source is unused
        logic [rv_isa_pkg::REG_IDX_W-1:0] rs2_idx;
        logic [XLEN-1:0]                  rs1_value;
        logic [XLEN-1:0]                  rs2_value;
        logic [XLEN-1:0]                  imm;
        logic [rv_isa_pkg::REG_IDX_W-1:0] dest;     // Zero means no register write
        rv_isa_pkg::alu_op_e              alu_op;
        logic                             use_imm;
        logic                             rd_mem;
        logic                             wr_mem;
        logic                             is_branch;
        logic                             branch_on_ne;
        logic                             halt;
        logic                             illegal;
    } id_ex_t;

    typedef struct packed {
        logic                             valid;
        logic [XLEN-1:0]                  npc;
        logic [rv_isa_pkg::REG_IDX_W-1:0] dest;
        logic [XLEN-1:0]                  alu_result;  // Also the LW/SW address
        logic [XLEN-1:0]                  store_data;
        logic                             rd_mem;
        logic                             wr_mem;
        logic                             halt;
        logic                             illegal;
    } ex_mem_t;

    typedef struct packed {
        logic                             valid;
        logic [XLEN-1:0]                  npc;
        logic [rv_isa_pkg::REG_IDX_W-1:0] dest;
        logic [XLEN-1:0]                  result;
        logic                             wr_en;
        logic                             halt;
        logic                             illegal;
    } mem_wb_t;

endpackage

//--- logic/fetch_port_if.sv
/*
 * Instruction fetch port onto the shared memory bus.
 * The arbiter grants in the same cycle and returns the word at once.
 */
interface fetch_port_if;

    logic                         req;    // Fetch wants the bus
    logic [rv_pipe_pkg::XLEN-1:0] addr;
    logic                         grant;  // Low while a load or store owns the bus
    logic [rv_pipe_pkg::XLEN-1:0] inst;   // Valid with grant

    modport requester (output req, addr, input grant, inst);
    modport arbiter (input req, addr, output grant, inst);

endinterface

//--- logic/fetch_stage.sv
/*
 * Program counter and IF/ID register.
 * Advances on an unstalled grant; a redirect from execute overrides.
 */
module fetch_stage #(
    parameter logic [rv_pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                         clock,
    input  logic                         reset,
    fetch_port_if.requester              fetch,
    input  logic                         stall,
    input  logic                         redirect,
    input  logic                         halted,
    input  logic [rv_pipe_pkg::XLEN-1:0] redirect_pc,
    output rv_pipe_pkg::if_id_t          if_id
);

    localparam rv_pipe_pkg::if_id_t BUBBLE =
        '{valid: 1'b0, pc: '0, npc: '0, inst: rv_isa_pkg::NOP_INST};

    logic [rv_pipe_pkg::XLEN-1:0] pc;
    logic [rv_pipe_pkg::XLEN-1:0] pc_plus4;

    assign pc_plus4   = pc + 32'd4;
    assign fetch.req  = !halted;  // Fetch stops for good once halted
    assign fetch.addr = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc    <= RESET_PC;
            if_id <= BUBBLE;
        end else if (redirect) begin  // Taken branch squashes this fetch
            pc    <= redirect_pc;
            if_id <= BUBBLE;
        end else if (!stall) begin    // Load-use stall holds PC and IF/ID
            if (fetch.grant) begin
                pc    <= pc_plus4;
                if_id <= '{valid: 1'b1, pc: pc, npc: pc_plus4, inst: fetch.inst};
            end else begin
                if_id <= BUBBLE;      // Bus busy with data, retry next cycle
            end
        end
    end

    // Branch target from execute must stay word aligned
    a_redirect_aligned: assert property (@(posedge clock) disable iff (reset)
        redirect |-> redirect_pc[1:0] == 2'b00)
        else $error("misaligned redirect target %h", redirect_pc);

endmodule

//--- logic/decode_stage.sv
/*
 * Instruction decoder and 32-entry register file.
 * Decode is combinational; the WB write shows through to a same-cycle read.
 */
module decode_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  rv_pipe_pkg::if_id_t  if_id,
    input  rv_pipe_pkg::mem_wb_t wb,
    output rv_pipe_pkg::id_ex_t  decoded
);

    logic [rv_pipe_pkg::XLEN-1:0]     regs [rv_isa_pkg::NUM_REGS];
    logic [31:0]                      inst;
    logic [2:0]                       funct3;
    logic [6:0]                       funct7;
    logic [rv_isa_pkg::REG_IDX_W-1:0] rd;
    logic [rv_isa_pkg::REG_IDX_W-1:0] rs1;
    logic [rv_isa_pkg::REG_IDX_W-1:0] rs2;
    logic [rv_pipe_pkg::XLEN-1:0]     imm_i;
    logic [rv_pipe_pkg::XLEN-1:0]     imm_s;
    logic [rv_pipe_pkg::XLEN-1:0]     imm_b;

    assign inst   = if_id.inst;
    assign funct3 = inst[rv_isa_pkg::FUNCT3_LSB +: 3];
    assign funct7 = inst[rv_isa_pkg::FUNCT7_LSB +: 7];
    assign rd     = inst[rv_isa_pkg::RD_LSB +: rv_isa_pkg::REG_IDX_W];
    assign rs1    = inst[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_IDX_W];
    assign rs2    = inst[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_IDX_W];
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // x0 reads zero, pending WB write wins over the array
    function automatic logic [rv_pipe_pkg::XLEN-1:0] read_reg(
        input logic [rv_isa_pkg::REG_IDX_W-1:0] idx
    );
        if (idx == '0)
            return '0;
        if (wb.wr_en && wb.dest == idx)
            return wb.result;
        return regs[idx];
    endfunction

    ////////////////////////////// Decode
    always_comb begin
        decoded       = '0;
        decoded.valid = if_id.valid;
        decoded.pc    = if_id.pc;
        decoded.npc   = if_id.npc;
        case (rv_isa_pkg::opcode_e'(inst[rv_isa_pkg::OPCODE_LSB +: 7]))
            rv_isa_pkg::OP: begin
                decoded.rs1_idx = rs1;
                decoded.rs2_idx = rs2;
                decoded.dest    = rd;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: decoded.alu_op = rv_isa_pkg::ADD;
                    {7'h20, 3'b000}: decoded.alu_op = rv_isa_pkg::SUB;
                    {7'h00, 3'b100}: decoded.alu_op = rv_isa_pkg::XOR;
                    {7'h00, 3'b110}: decoded.alu_op = rv_isa_pkg::OR;
                    {7'h00, 3'b111}: decoded.alu_op = rv_isa_pkg::AND;
                    default:         decoded.illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::OP_IMM, rv_isa_pkg::LOAD: begin  // ADDI and LW share the I form
                decoded.rs1_idx = rs1;
                decoded.dest    = rd;
                decoded.imm     = imm_i;
                decoded.use_imm = 1'b1;
                decoded.rd_mem  = inst[4] == 1'b0;       // LOAD has opcode bit 4 clear
                decoded.illegal = funct3 != (decoded.rd_mem ? 3'b010 : 3'b000);
            end
            rv_isa_pkg::STORE: begin
                decoded.rs1_idx = rs1;
                decoded.rs2_idx = rs2;   // Store data
                decoded.imm     = imm_s;
                decoded.use_imm = 1'b1;
                decoded.wr_mem  = 1'b1;
                decoded.illegal = funct3 != 3'b010;      // SW only
            end
            rv_isa_pkg::BRANCH: begin
                decoded.rs1_idx      = rs1;
                decoded.rs2_idx      = rs2;
                decoded.imm          = imm_b;
                decoded.is_branch    = 1'b1;
                decoded.branch_on_ne = funct3[0];        // BNE
                decoded.illegal      = funct3[2:1] != 2'b00;
            end
            rv_isa_pkg::SYSTEM: begin
                decoded.halt    = inst == rv_isa_pkg::WFI_INST;
                decoded.illegal = inst != rv_isa_pkg::WFI_INST;
            end
            default: decoded.illegal = 1'b1;
        endcase
        if (decoded.illegal) begin  // Illegal commits with no side effects
            decoded.dest   = '0;
            decoded.rd_mem = 1'b0;
            decoded.wr_mem = 1'b0;
            decoded.is_branch = 1'b0;
        end
        decoded.rs1_value = read_reg(decoded.rs1_idx);
        decoded.rs2_value = read_reg(decoded.rs2_idx);
    end

    ////////////////////////////// Register file
    always_ff @(posedge clock) begin
        if (wb.wr_en)
            regs[wb.dest] <= wb.result;
    end

    // Memory stage never raises a write for x0
    a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
        wb.wr_en |-> wb.dest != '0)
        else $error("register write aimed at x0");

endmodule

//--- logic/issue_stage.sv
/*
 * Load-use hazard check, operand forwarding and the ID/EX register.
 * Forwarded values come from the execute and memory results of this cycle.
 */
module issue_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  rv_pipe_pkg::id_ex_t  decoded,
    input  rv_pipe_pkg::ex_mem_t ex_fwd,
    input  rv_pipe_pkg::mem_wb_t mem_fwd,
    input  logic                 redirect,
    output logic                 stall,
    output rv_pipe_pkg::id_ex_t  id_ex
);

    rv_pipe_pkg::id_ex_t issued;

    // Youngest producer wins; x0 never forwards
    function automatic logic [rv_pipe_pkg::XLEN-1:0] pick(
        input logic [rv_isa_pkg::REG_IDX_W-1:0] idx,
        input logic [rv_pipe_pkg::XLEN-1:0]     rf_value
    );
        if (idx == '0)
            return rf_value;
        if (ex_fwd.valid && ex_fwd.dest == idx)
            return ex_fwd.alu_result;
        if (mem_fwd.wr_en && mem_fwd.dest == idx)
            return mem_fwd.result;
        return rf_value;
    endfunction

    // Load in EX has no data yet, so its consumer waits one cycle
    assign stall = decoded.valid && ex_fwd.valid && ex_fwd.rd_mem && ex_fwd.dest != '0
                 && (ex_fwd.dest == decoded.rs1_idx || ex_fwd.dest == decoded.rs2_idx);

    always_comb begin
        issued           = decoded;
        issued.rs1_value = pick(decoded.rs1_idx, decoded.rs1_value);
        issued.rs2_value = pick(decoded.rs2_idx, decoded.rs2_value);
    end

    always_ff @(posedge clock) begin
        if (reset || stall || redirect)
            id_ex <= '0;  // Bubble
        else
            id_ex <= issued;
    end

    // Stalled consumer still waits in decode one cycle later
    a_stall_holds: assert property (@(posedge clock) disable iff (reset)
        stall |=> decoded.valid && decoded.pc == $past(decoded.pc))
        else $error("instruction lost from decode during a load-use stall");

endmodule

//--- logic/execute_stage.sv
/*
 * ALU, branch compare and the EX/MEM register.
 * ex_fwd is this cycle's result for forwarding into ID/EX.
 */
module execute_stage (
    input  logic                         clock,
    input  logic                         reset,
    input  rv_pipe_pkg::id_ex_t          id_ex,
    output logic                         redirect,
    output logic [rv_pipe_pkg::XLEN-1:0] redirect_pc,
    output rv_pipe_pkg::ex_mem_t         ex_fwd,
    output rv_pipe_pkg::ex_mem_t         ex_mem
);

    logic [rv_pipe_pkg::XLEN-1:0] op_b;
    logic [rv_pipe_pkg::XLEN-1:0] alu_out;
    logic                         equal;

    assign op_b = id_ex.use_imm ? id_ex.imm : id_ex.rs2_value;

    always_comb begin
        case (id_ex.alu_op)
            rv_isa_pkg::SUB: alu_out = id_ex.rs1_value - op_b;
            rv_isa_pkg::AND: alu_out = id_ex.rs1_value & op_b;
            rv_isa_pkg::OR:  alu_out = id_ex.rs1_value | op_b;
            rv_isa_pkg::XOR: alu_out = id_ex.rs1_value ^ op_b;
            default:         alu_out = id_ex.rs1_value + op_b;  // ADD, LW/SW address
        endcase
    end

    ////////////////////////////// Branch
    assign equal       = id_ex.rs1_value == id_ex.rs2_value;
    assign redirect    = id_ex.valid && id_ex.is_branch && (equal ^ id_ex.branch_on_ne);
    assign redirect_pc = id_ex.pc + id_ex.imm;

    // Branch carries dest 0, so it commits without a write
    always_comb begin
        ex_fwd.valid      = id_ex.valid;
        ex_fwd.npc        = id_ex.npc;
        ex_fwd.dest       = id_ex.dest;
        ex_fwd.alu_result = alu_out;
        ex_fwd.store_data = id_ex.rs2_value;
        ex_fwd.rd_mem     = id_ex.rd_mem;
        ex_fwd.wr_mem     = id_ex.wr_mem;
        ex_fwd.halt       = id_ex.halt;
        ex_fwd.illegal    = id_ex.illegal;
    end

    always_ff @(posedge clock) begin
        if (reset)
            ex_mem <= '0;
        else
            ex_mem <= ex_fwd;
    end

endmodule

//--- logic/memory_stage.sv
/*
 * Shared bus arbitration, load/store access and the MEM/WB register.
 * Data access beats fetch; status latches the first halt or illegal commit.
 */
module memory_stage (
    input  logic                          clock,
    input  logic                          reset,
    input  rv_pipe_pkg::ex_mem_t          ex_mem,
    fetch_port_if.arbiter                 fetch,
    output rv_pipe_pkg::bus_cmd_e         mem_cmd,
    output logic [rv_pipe_pkg::XLEN-1:0]  mem_addr,
    output logic [rv_pipe_pkg::XLEN-1:0]  mem_wdata,
    input  logic [rv_pipe_pkg::XLEN-1:0]  mem_rdata,
    output rv_pipe_pkg::mem_wb_t          mem_fwd,
    output rv_pipe_pkg::mem_wb_t          mem_wb,
    output rv_pipe_pkg::status_e          status
);

    logic stopped;      // Nothing younger than a halt may take effect
    logic data_access;

    assign stopped     = status != rv_pipe_pkg::RUNNING
                       || (mem_wb.valid && (mem_wb.halt || mem_wb.illegal));
    assign data_access = ex_mem.valid && !stopped && (ex_mem.rd_mem || ex_mem.wr_mem);

    ////////////////////////////// Bus
    assign fetch.grant = fetch.req && !data_access;
    assign fetch.inst  = mem_rdata;  // Same-cycle answer
    assign mem_wdata   = ex_mem.store_data;

    always_comb begin
        if (data_access) begin
            mem_cmd  = ex_mem.wr_mem ? rv_pipe_pkg::BUS_STORE : rv_pipe_pkg::BUS_LOAD;
            mem_addr = ex_mem.alu_result;
        end else begin
            mem_cmd  = fetch.req ? rv_pipe_pkg::BUS_LOAD : rv_pipe_pkg::BUS_NONE;
            mem_addr = fetch.addr;
        end
    end

    ////////////////////////////// Result and MEM/WB
    always_comb begin
        mem_fwd.valid   = ex_mem.valid && !stopped;
        mem_fwd.npc     = ex_mem.npc;
        mem_fwd.dest    = ex_mem.dest;
        mem_fwd.result  = ex_mem.rd_mem ? mem_rdata : ex_mem.alu_result;
        mem_fwd.wr_en   = mem_fwd.valid && ex_mem.dest != '0;
        mem_fwd.halt    = ex_mem.halt;
        mem_fwd.illegal = ex_mem.illegal;
    end

    always_ff @(posedge clock) begin
        if (reset)
            mem_wb <= '0;
        else
            mem_wb <= mem_fwd;
    end

    always_ff @(posedge clock) begin
        if (reset)
            status <= rv_pipe_pkg::RUNNING;
        else if (status == rv_pipe_pkg::RUNNING && mem_wb.valid) begin
            if (mem_wb.illegal)
                status <= rv_pipe_pkg::ILLEGAL;
            else if (mem_wb.halt)
                status <= rv_pipe_pkg::HALTED;
        end
    end

    // Word accesses only, so a data address is always aligned
    a_data_aligned: assert property (@(posedge clock) disable iff (reset)
        data_access |-> ex_mem.alu_result[1:0] == 2'b00)
        else $error("misaligned data address %h", ex_mem.alu_result);

endmodule

//--- logic/rv_pipeline_top.sv
/*
 * Five-stage RV32 pipeline on one shared memory bus.
 * Commit ports show each instruction leaving MEM/WB.
 */
module rv_pipeline_top #(
    parameter logic [rv_pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                         clock,
    input  logic                         reset,
    output rv_pipe_pkg::bus_cmd_e        mem_cmd,
    output logic [rv_pipe_pkg::XLEN-1:0] mem_addr,
    output logic [rv_pipe_pkg::XLEN-1:0] mem_wdata,
    input  logic [rv_pipe_pkg::XLEN-1:0] mem_rdata,
    output logic                         commit_valid,
    output logic                         commit_wr_en,
    output logic [4:0]                   commit_wr_idx,
    output logic [rv_pipe_pkg::XLEN-1:0] commit_wr_data,
    output logic [rv_pipe_pkg::XLEN-1:0] commit_npc,
    output rv_pipe_pkg::status_e         status
);

    fetch_port_if fetch_port ();

    rv_pipe_pkg::if_id_t          if_id;
    rv_pipe_pkg::id_ex_t          decoded;
    rv_pipe_pkg::id_ex_t          id_ex;
    rv_pipe_pkg::ex_mem_t         ex_fwd;
    rv_pipe_pkg::ex_mem_t         ex_mem;
    rv_pipe_pkg::mem_wb_t         mem_fwd;
    rv_pipe_pkg::mem_wb_t         mem_wb;
    logic                         stall;
    logic                         redirect;
    logic [rv_pipe_pkg::XLEN-1:0] redirect_pc;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clock       (clock),
        .reset       (reset),
        .fetch       (fetch_port.requester),
        .stall       (stall),
        .redirect    (redirect),
        .halted      (status != rv_pipe_pkg::RUNNING),
        .redirect_pc (redirect_pc),
        .if_id       (if_id)
    );

    decode_stage u_decode (
        .clock   (clock),
        .reset   (reset),
        .if_id   (if_id),
        .wb      (mem_wb),   // Register write port
        .decoded (decoded)
    );

    issue_stage u_issue (
        .clock    (clock),
        .reset    (reset),
        .decoded  (decoded),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .redirect (redirect),
        .stall    (stall),
        .id_ex    (id_ex)
    );

    execute_stage u_execute (
        .clock       (clock),
        .reset       (reset),
        .id_ex       (id_ex),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_fwd      (ex_fwd),
        .ex_mem      (ex_mem)
    );

    memory_stage u_memory (
        .clock     (clock),
        .reset     (reset),
        .ex_mem    (ex_mem),
        .fetch     (fetch_port.arbiter),
        .mem_cmd   (mem_cmd),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_fwd   (mem_fwd),
        .mem_wb    (mem_wb),
        .status    (status)
    );

    // Commit straight from MEM/WB
    assign commit_valid   = mem_wb.valid;
    assign commit_wr_en   = mem_wb.wr_en;
    assign commit_wr_idx  = mem_wb.dest;
    assign commit_wr_data = mem_wb.result;
    assign commit_npc     = mem_wb.npc;

endmodule

//--- verif/rv_pipeline_tb.sv
/*
 * Testbench for the five-stage pipeline. Builds programs, models the shared
 * memory bus, and checks every commit against an instruction-set model.
 */
module rv_pipeline_tb;

    localparam logic [31:0] DATA_BASE = 32'h200;  // Upper half of memory
    localparam logic [31:0] WFI       = 32'h1050_0073;

    logic                  clock;
    logic                  reset;
    rv_pipe_pkg::bus_cmd_e mem_cmd;
    logic [31:0]           mem_addr;
    logic [31:0]           mem_wdata;
    logic [31:0]           mem_rdata;
    logic                  commit_valid;
    logic                  commit_wr_en;
    logic [4:0]            commit_wr_idx;
    logic [31:0]           commit_wr_data;
    logic [31:0]           commit_npc;
    rv_pipe_pkg::status_e  status;

    logic [31:0] mem [256];
    logic [31:0] ref_mem [256];
    logic [31:0] prog [$];
    logic [31:0] exp_npc [$];
    logic        exp_wen [$];
    logic [4:0]  exp_idx [$];
    logic [31:0] exp_data [$];
    rv_pipe_pkg::status_e exp_status;
    logic [31:0] seed = 32'hda03;
    int          cycle_count;
    int          cycle_limit = 1000;

    rv_pipeline_top #(.RESET_PC(32'h0)) dut (.*);

    always #4 clock = ~clock;

    //////////////////////////////
    // Failure reporting
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string field, input logic [31:0] got,
                                  input logic [31:0] want);
        abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                            $time, field, got, want));
    endtask

    //////////////////////////////
    // Program building
    function automatic logic [31:0] xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};  // Base is x0
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic ne);
        return {imm[12], imm[10:5], rs2, rs1, 2'b00, ne, imm[4:1], imm[11], 7'h63};
    endfunction

    // Random R-type over x0..x7
    function automatic logic [31:0] rand_alu(input logic [4:0] rd);
        logic [4:0] rs1;
        logic [4:0] rs2;
        rs1 = 5'(xorshift() % 8);
        rs2 = 5'(xorshift() % 8);
        case (xorshift() % 5)
            0:       return enc_r(7'h00, rs2, rs1, 3'b000, rd);
            1:       return enc_r(7'h20, rs2, rs1, 3'b000, rd);
            2:       return enc_r(7'h00, rs2, rs1, 3'b111, rd);
            3:       return enc_r(7'h00, rs2, rs1, 3'b110, rd);
            default: return enc_r(7'h00, rs2, rs1, 3'b100, rd);
        endcase
    endfunction

    task automatic init_regs();
        prog.delete();
        for (int r = 1; r < 8; r++)
            prog.push_back(enc_i(12'(xorshift()), 5'd0, 3'b000, 5'(r), 7'h13));
    endtask

    task automatic build_random(input int len);
        int kind;
        int skip;
        int last;
        init_regs();
        last = prog.size() + len;  // Index of the closing WFI
        for (int i = 0; i < len; i++) begin
            kind = xorshift() % 8;
            if (kind < 4)
                prog.push_back(rand_alu(5'(xorshift() % 8)));
            else if (kind == 4)
                prog.push_back(enc_i(12'(xorshift()), 5'(xorshift() % 8), 3'b000,
                                     5'(xorshift() % 8), 7'h13));
            else if (kind == 5)
                prog.push_back(enc_i(12'(DATA_BASE + 4 * (xorshift() % 8)), 5'd0, 3'b010,
                                     5'(1 + xorshift() % 7), 7'h03));
            else if (kind == 6)
                prog.push_back(enc_s(12'(DATA_BASE + 4 * (xorshift() % 8)),
                                     5'(1 + xorshift() % 7)));
            else begin
                skip = 1 + xorshift() % 3;
                if (prog.size() + 1 + skip > last)
                    skip = last - prog.size() - 1;
                prog.push_back(enc_b(13'(4 * (skip + 1)), 5'(1 + xorshift() % 7),
                                     5'(1 + xorshift() % 7), 1'(xorshift() % 2)));
            end
        end
        prog.push_back(WFI);
    endtask

    //////////////////////////////
    // Reference instruction-set model
    function automatic void ref_run();
        logic [31:0] rf [32];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] val;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        logic        wen;
        logic        stop;
        exp_npc.delete();
        exp_wen.delete();
        exp_idx.delete();
        exp_data.delete();
        foreach (rf[i]) rf[i] = '0;
        pc   = '0;
        stop = 1'b0;
        exp_status = rv_pipe_pkg::RUNNING;
        for (int step = 0; step < 1000 && !stop; step++) begin
            inst = ref_mem[pc[9:2]];
            rd   = inst[11:7];
            a    = rf[inst[19:15]];
            b    = rf[inst[24:20]];
            wen  = 1'b0;
            val  = '0;
            case (inst[6:0])
                7'h33: begin
                    wen = 1'b1;
                    case ({inst[31:25], inst[14:12]})
                        10'h000: val = a + b;
                        10'h100: val = a - b;
                        10'h007: val = a & b;
                        10'h006: val = a | b;
                        10'h004: val = a ^ b;
                        default: stop = 1'b1;
                    endcase
                end
                7'h13: begin
                    wen  = 1'b1;
                    val  = a + {{20{inst[31]}}, inst[31:20]};
                    stop = inst[14:12] != 3'b000;
                end
                7'h03: begin
                    wen  = 1'b1;
                    val  = ref_mem[8'((a + {{20{inst[31]}}, inst[31:20]}) >> 2)];
                    stop = inst[14:12] != 3'b010;
                end
                7'h23: ref_mem[8'((a + {{20{inst[31]}}, inst[31:25], inst[11:7]}) >> 2)] = b;
                7'h63: stop = inst[14:13] != 2'b00;
                default: stop = inst != WFI;
            endcase
            if (stop) begin  // Illegal commits without a write
                wen = 1'b0;
                exp_status = rv_pipe_pkg::ILLEGAL;
            end else if (inst == WFI) begin
                stop = 1'b1;
                exp_status = rv_pipe_pkg::HALTED;
            end
            wen = wen && rd != 0;
            exp_npc.push_back(pc + 4);
            exp_wen.push_back(wen);
            exp_idx.push_back(wen ? rd : 5'd0);
            exp_data.push_back(val);
            if (wen)
                rf[rd] = val;
            if (!stop && inst[6:0] == 7'h63 && ((a == b) ^ inst[12]))
                pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            else
                pc = pc + 4;
        end
    endfunction

    //////////////////////////////
    // Bus memory model
    assign mem_rdata = mem[mem_addr[9:2]];  // Same-cycle answer

    always @(posedge clock) begin
        if (!reset && mem_cmd == rv_pipe_pkg::BUS_STORE) begin
            assert (mem_addr >= DATA_BASE && mem_addr < 32'h400)
            else abort_run($sformatf("Store at %h went outside the data region", mem_addr));
            mem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    // Hang guard
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
            abort_run("Timeout: the pipeline stopped committing before the program ended");
    end

    //////////////////////////////
    // Commit checker
    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            assert (exp_npc.size() > 0)
            else abort_run("An instruction committed after the program had ended");
            assert (commit_npc == exp_npc[0])
            else value_mismatch("commit_npc", commit_npc, exp_npc[0]);
            assert (commit_wr_en == exp_wen[0])
            else value_mismatch("commit_wr_en", 32'(commit_wr_en), 32'(exp_wen[0]));
            if (exp_wen[0]) begin
                assert (commit_wr_idx == exp_idx[0])
                else value_mismatch("commit_wr_idx", 32'(commit_wr_idx), 32'(exp_idx[0]));
                assert (commit_wr_data == exp_data[0])
                else value_mismatch("commit_wr_data", commit_wr_data, exp_data[0]);
            end
            void'(exp_npc.pop_front());
            void'(exp_wen.pop_front());
            void'(exp_idx.pop_front());
            void'(exp_data.pop_front());
        end
    end

    // Load, reset, run to the end, then check status holds
    task automatic run_program();
        @(posedge clock);
        #1;
        reset = 1'b1;
        @(posedge clock);
        #1;
        for (int i = 0; i < 256; i++)
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;  // Fill from whole address
        foreach (prog[i]) mem[i] = prog[i];
        ref_mem = mem;
        ref_run();
        cycle_limit = 6 * exp_npc.size() + 50;
        cycle_count = 0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        assert (!commit_valid)
        else value_mismatch("commit_valid after reset", 32'(commit_valid), 32'd0);
        assert (status == rv_pipe_pkg::RUNNING)
        else value_mismatch("status after reset", 32'(status), 32'(rv_pipe_pkg::RUNNING));
        while (exp_npc.size() > 0 || status == rv_pipe_pkg::RUNNING)
            @(negedge clock);
        repeat (6) begin
            assert (status == exp_status)
            else value_mismatch("status", 32'(status), 32'(exp_status));
            @(negedge clock);
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        // Dependent ALU chain
        init_regs();
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd4, 3'b100, 5'd5));
        prog.push_back(enc_i(12'h7ff, 5'd5, 3'b000, 5'd5, 7'h13));
        prog.push_back(enc_r(7'h00, 5'd5, 5'd4, 3'b110, 5'd6));
        prog.push_back(enc_r(7'h00, 5'd6, 5'd5, 3'b111, 5'd7));
        prog.push_back(WFI);
        run_program();
        // Load-use, then store to load through memory
        init_regs();
        prog.push_back(enc_i(12'(DATA_BASE), 5'd0, 3'b010, 5'd1, 7'h03));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(enc_s(12'(DATA_BASE + 4), 5'd3));
        prog.push_back(enc_i(12'(DATA_BASE + 4), 5'd0, 3'b010, 5'd5, 7'h03));
        prog.push_back(enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));
        prog.push_back(WFI);
        run_program();
        // Taken and untaken branches
        init_regs();
        prog.push_back(enc_b(13'd8, 5'd1, 5'd1, 1'b0));
        prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd2, 7'h13));
        prog.push_back(enc_b(13'd8, 5'd1, 5'd1, 1'b1));
        prog.push_back(enc_i(12'd2, 5'd0, 3'b000, 5'd3, 7'h13));
        prog.push_back(enc_b(13'd12, 5'd2, 5'd3, 1'b1));
        prog.push_back(enc_i(12'd3, 5'd0, 3'b000, 5'd4, 7'h13));
        prog.push_back(enc_i(12'd4, 5'd0, 3'b000, 5'd5, 7'h13));
        prog.push_back(enc_b(13'd8, 5'd3, 5'd2, 1'b0));
        prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd6, 7'h13));
        prog.push_back(WFI);
        run_program();
        // Undefined encoding
        init_regs();
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(32'hffff_ffff);
        prog.push_back(enc_i(12'd9, 5'd0, 3'b000, 5'd4, 7'h13));
        prog.push_back(WFI);
        run_program();
        for (int n = 0; n < 4; n++) begin
            build_random(60);
            run_program();
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- rv_pipeline.f
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/fetch_port_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/issue_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/rv_pipeline_top.sv
verif/rv_pipeline_tb.sv

//--- Bender.yml
package:
  name: rv_pipeline

sources:
  - logic/rv_isa_pkg.sv
  - logic/rv_pipe_pkg.sv
  - logic/fetch_port_if.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/issue_stage.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/rv_pipeline_top.sv
  - target: test
    files:
      - verif/rv_pipeline_tb.sv
